// ==== include/main_defs.svh ====
/*
 * widths, memory map, i/o register offsets and interrupt levels
 * of the main 68000 bus glue. Include it wherever one is needed.
 */
`ifndef MAIN_DEFS_SVH
`define MAIN_DEFS_SVH

`define MAIN_AW 23        // word address, cpu bits 23 to 1
`define MAIN_DW 16

// memory map on address bits 23 to 20, higher codes unmapped
`define REGION_ROM  4'd0
`define REGION_RAM  4'd1
`define REGION_DISP 4'd2
`define REGION_IO   4'd3

// i/o page registers on address bits 4 to 1
`define IO_CAB0    4'd0
`define IO_CAB1    4'd1
`define IO_DIPS    4'd2
`define IO_SND     4'd3
`define IO_MCU     4'd4
`define IO_VCLR    4'd5
`define IO_PRISEL  4'd6
`define IO_MIXPSEL 4'd7

`define IPL_VBL 3'd6      // vertical blank
`define IPL_SEC 3'd5      // sub cpu
`define IPL_EXT 3'd4      // external line

`define DISP_BLANK_DLY 2  // wait after a blank starts
`define OPEN_BUS 16'hffff

`endif

// ==== hw/main_pkg.sv ====
/*
 * types shared by the main cpu bus glue: the cpu bus bundle,
 * i/o strobes, cabinet inputs and the decoder enums
 */
`include "main_defs.svh"

package main_pkg;

    typedef logic [`MAIN_DW-1:0] word_t;

    typedef struct packed {
        logic [`MAIN_AW:1] addr;
        logic              as_n;
        logic              uds_n;
        logic              lds_n;
        logic              rnw;
        word_t             dout;    // cpu write data
    } cpu_bus_t;

    // each bit lives for one cycle at the start of an access
    typedef struct packed {
        logic snd_wr;
        logic mcu_wr;
        logic mcu_rd;
        logic vclr_wr;
        logic prisel_wr;
        logic mixpsel_wr;
        logic cab0_rd;
        logic cab1_rd;
        logic dips_rd;
    } io_strobe_t;

    typedef struct packed {
        logic [8:0] joystick1;
        logic [8:0] joystick2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

    typedef enum logic [2:0] {IDLE, WAIT_MEM, WAIT_BLANK, BLANK_DLY, ACK} bus_state_e;

    typedef enum logic [2:0] {ROM, RAM, DISP, IO, NONE} region_e;

    typedef enum logic [3:0] {
        REG_CAB0    = `IO_CAB0,
        REG_CAB1    = `IO_CAB1,
        REG_DIPS    = `IO_DIPS,
        REG_SND     = `IO_SND,
        REG_MCU     = `IO_MCU,
        REG_VCLR    = `IO_VCLR,
        REG_PRISEL  = `IO_PRISEL,
        REG_MIXPSEL = `IO_MIXPSEL
    } io_reg_e;

endpackage

// ==== hw/bus_ctrl.sv ====
/*
 * main cpu address decoder and dtack generator.
 * Picks the region, raises one-cycle i/o strobes and holds dtack_n
 * low from the end of the region's wait until as_n is released.
 */
`include "main_defs.svh"

module bus_ctrl import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  logic       lvbl,
    input  logic       lhbl,
    input  logic       rom_ok,
    input  logic       ram_ok,
    output logic       dtack_n,
    output logic       rom_cs,
    output logic       ram_cs,
    output region_e    region,
    output io_strobe_t strobe
);

    localparam logic [1:0] DLY_LOAD = 2'(`DISP_BLANK_DLY - 1);

    bus_state_e state;
    io_reg_e    reg_sel;
    logic [1:0] dly_cnt;     // blank delay countdown
    logic       bus_act;
    logic       start;       // first cycle of an access
    logic       blank;
    logic       mem_ok;
    logic       wr;
    logic       rd;

    assign bus_act = ~bus.as_n & ~(bus.uds_n & bus.lds_n);
    assign start   = bus_act & (state == IDLE);
    assign blank   = ~lvbl | ~lhbl;
    assign mem_ok  = (region == ROM) ? rom_ok : ram_ok;
    assign reg_sel = io_reg_e'(bus.addr[4:1]);

    assign wr = start & ~bus.rnw & (region == IO);
    assign rd = start &  bus.rnw & (region == IO);

    always_comb begin
        case (bus.addr[`MAIN_AW:`MAIN_AW-3])
            `REGION_ROM:  region = ROM;
            `REGION_RAM:  region = RAM;
            `REGION_DISP: region = DISP;
            `REGION_IO:   region = IO;
            default:      region = NONE;
        endcase
    end

    assign rom_cs = bus_act & (region == ROM);
    assign ram_cs = bus_act & ((region == RAM) | (region == DISP));  // vram shares the port

    // registers mirror over the whole i/o page
    always_comb begin
        strobe = '0;
        case (reg_sel)
            REG_CAB0:    strobe.cab0_rd    = rd;
            REG_CAB1:    strobe.cab1_rd    = rd;
            REG_DIPS:    strobe.dips_rd    = rd;
            REG_SND:     strobe.snd_wr     = wr;
            REG_MCU: begin
                strobe.mcu_wr = wr;
                strobe.mcu_rd = rd;        // also acks the sub cpu irq
            end
            REG_VCLR:    strobe.vclr_wr    = wr;
            REG_PRISEL:  strobe.prisel_wr  = wr;
            REG_MIXPSEL: strobe.mixpsel_wr = wr;
            default: ;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            dly_cnt <= '0;
        end else if (state != IDLE && bus.as_n) begin
            state <= IDLE;                 // access over
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        case (region)
                            ROM, RAM: state <= mem_ok ? ACK : WAIT_MEM;
                            DISP: begin
                                state   <= blank ? BLANK_DLY : WAIT_BLANK;
                                dly_cnt <= DLY_LOAD;
                            end
                            default: state <= ACK;    // registers and open bus
                        endcase
                    end
                end
                WAIT_MEM: begin
                    if (mem_ok)
                        state <= ACK;
                end
                WAIT_BLANK: begin
                    if (blank) begin
                        state   <= BLANK_DLY;
                        dly_cnt <= DLY_LOAD;
                    end
                end
                BLANK_DLY: begin
                    if (dly_cnt == 2'd0)
                        state <= ACK;
                    else
                        dly_cnt <= dly_cnt - 2'd1;
                end
                default: ;                 // ACK waits for as_n
            endcase
        end
    end

    assign dtack_n = (state != ACK);

endmodule

// ==== hw/irq_ctrl.sv ====
/*
 * interrupt sources of the main cpu. Latches vertical blank and
 * sub cpu requests until cleared and encodes the 68000 ipl lines.
 */
`include "main_defs.svh"

module irq_ctrl import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       sec2,
    input  logic       nexirq,    // active low
    input  io_strobe_t strobe,
    output logic [2:0] ipl_n
);

    logic       lvbl_l;
    logic       sec2_l;
    logic       vint;
    logic       secirq;
    logic [2:0] level;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;           // no false blank edge out of reset
            sec2_l <= 1'b1;
            vint   <= 1'b0;
            secirq <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            sec2_l <= sec2;

            if (strobe.vclr_wr)
                vint <= 1'b0;
            else if (lvbl_l && !lvbl)
                vint <= 1'b1;         // blank start

            if (strobe.mcu_rd)
                secirq <= 1'b0;       // cpu read the mcu word
            else if (!sec2_l && sec2)
                secirq <= 1'b1;
        end
    end

    always_comb begin
        if (vint)
            level = `IPL_VBL;
        else if (secirq)
            level = `IPL_SEC;
        else if (!nexirq)
            level = `IPL_EXT;
        else
            level = 3'd0;
    end

    assign ipl_n = ~level;

endmodule

// ==== hw/write_latches.sv ====
/*
 * cpu written registers: sound command with its request pulse,
 * mcu data word, colour priority and object dma select
 */
module write_latches import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  io_strobe_t strobe,
    output logic [7:0] snd_latch,
    output logic       snreq,
    output word_t      mcu_din,
    output logic [7:0] prisel,
    output logic       mixpsel
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd_latch <= 8'd0;
            snreq     <= 1'b0;
            mcu_din   <= '0;
            prisel    <= 8'd0;
            mixpsel   <= 1'b0;
        end else begin
            snreq <= strobe.snd_wr;        // one cycle, new command visible

            if (strobe.snd_wr)
                snd_latch <= bus.dout[7:0];

            if (strobe.mcu_wr)
                mcu_din <= bus.dout;       // full word to the sub cpu

            // colour mixer priority
            if (strobe.prisel_wr)
                prisel <= bus.dout[7:0];

            if (strobe.mixpsel_wr)
                mixpsel <= bus.dout[0];    // obj buffer dma
        end
    end

endmodule

// ==== hw/read_mux.sv ====
/*
 * read data path of the main cpu. Formats the cabinet words and
 * registers the selected source onto cpu_din, memory data on every
 * cycle and register data once at the start of the access.
 */
`include "main_defs.svh"

module read_mux import main_pkg::*; (
    input  logic       clk,
    input  cpu_bus_t   bus,
    input  region_e    region,
    input  io_strobe_t strobe,
    input  logic       lvbl,
    input  cab_in_t    cab,
    input  word_t      rom_data,
    input  word_t      ram_data,
    input  word_t      mcu_dout,
    output word_t      cpu_din
);

    word_t cab0;
    word_t cab1;
    word_t dips;
    word_t reg_dout;
    logic  bus_rd;
    logic  rd_seen;    // read already running last cycle

    assign cab0 = {cab.joystick2[7:0], cab.joystick1[7:0]};
    assign cab1 = {
        8'hff,
        ~lvbl,
        cab.service,
        cab.coin,
        cab.start,
        cab.joystick2[8],
        cab.joystick1[8]
    };
    assign dips = {cab.dipsw_b, cab.dipsw_a};

    always_comb begin
        if (strobe.cab0_rd)
            reg_dout = cab0;
        else if (strobe.cab1_rd)
            reg_dout = cab1;
        else if (strobe.dips_rd)
            reg_dout = dips;
        else if (strobe.mcu_rd)
            reg_dout = mcu_dout;
        else
            reg_dout = `OPEN_BUS;   // unmapped or write-only
    end

    assign bus_rd = ~bus.as_n & bus.rnw & ~(bus.uds_n & bus.lds_n);

    always_ff @(posedge clk) begin
        rd_seen <= bus_rd;
    end

    always_ff @(posedge clk) begin
        if (bus_rd) begin
            case (region)
                ROM:       cpu_din <= rom_data;
                RAM, DISP: cpu_din <= ram_data;
                default: begin
                    if (!rd_seen)
                        cpu_din <= reg_dout;   // capture once, then hold
                end
            endcase
        end
    end

endmodule

// ==== hw/main_glue.sv ====
/*
 * bus glue around the main 68000. Takes the cpu bus as one struct
 * and returns read data, dtack_n and the interrupt level.
 */
module main_glue import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    output word_t      cpu_din,
    output logic       dtack_n,
    output logic [2:0] ipl_n,
    // video timing and interrupt sources
    input  logic       lvbl,
    input  logic       lhbl,
    input  logic       sec2,
    input  logic       nexirq,
    // memories
    output logic       rom_cs,
    input  logic       rom_ok,
    input  word_t      rom_data,
    output logic       ram_cs,
    input  logic       ram_ok,
    input  word_t      ram_data,
    // sub cpu and sound
    input  word_t      mcu_dout,
    output word_t      mcu_din,
    output logic [7:0] snd_latch,
    output logic       snreq,
    // video mixer
    output logic [7:0] prisel,
    output logic       mixpsel,
    input  cab_in_t    cab
);

    region_e    region;
    io_strobe_t strobe;

    bus_ctrl bus_ctrl_inst (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus),
        .lvbl    (lvbl),
        .lhbl    (lhbl),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .dtack_n (dtack_n),
        .rom_cs  (rom_cs),
        .ram_cs  (ram_cs),
        .region  (region),
        .strobe  (strobe)
    );

    irq_ctrl irq_ctrl_inst (
        .clk    (clk),
        .rst    (rst),
        .lvbl   (lvbl),
        .sec2   (sec2),
        .nexirq (nexirq),
        .strobe (strobe),
        .ipl_n  (ipl_n)
    );

    write_latches write_latches_inst (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .strobe    (strobe),
        .snd_latch (snd_latch),
        .snreq     (snreq),
        .mcu_din   (mcu_din),
        .prisel    (prisel),
        .mixpsel   (mixpsel)
    );

    read_mux read_mux_inst (
        .clk      (clk),
        .bus      (bus),
        .region   (region),
        .strobe   (strobe),
        .lvbl     (lvbl),
        .cab      (cab),
        .rom_data (rom_data),
        .ram_data (ram_data),
        .mcu_dout (mcu_dout),
        .cpu_din  (cpu_din)
    );

endmodule

// ==== verif/main_glue_sva.sv ====
/*
 * assertion checker for the main bus glue, bound into main_glue.
 * Checks acknowledge timing, chip selects, read data, write latches and ipl_n.
 */
`include "main_defs.svh"

module main_glue_sva import main_pkg::*; (
    input logic       clk,
    input logic       rst,
    input cpu_bus_t   bus,
    input logic       lvbl,
    input logic       lhbl,
    input logic       sec2,
    input logic       nexirq,
    input logic       rom_ok,
    input logic       ram_ok,
    input word_t      rom_data,
    input word_t      ram_data,
    input word_t      mcu_dout,
    input cab_in_t    cab,
    input word_t      cpu_din,
    input logic       dtack_n,
    input logic [2:0] ipl_n,
    input logic       rom_cs,
    input logic       ram_cs,
    input logic [7:0] snd_latch,
    input logic       snreq,
    input word_t      mcu_din,
    input logic [7:0] prisel,
    input logic       mixpsel
);
    timeunit 1ns;
    timeprecision 100ps;

    int    fail_cnt = 0;
    logic  rst_q = 1'b0;
    logic  dtack_q, as_q, acc_q, rom_ok_q, ram_ok_q;
    logic  blank_q1, blank_q2, blank_q3;
    logic  snd_q, mcuwr_q, pri_q, mix_q;
    word_t dout_q, rom_q, ram_q, rd_word, rd_exp;
    logic  lvbl_m, sec2_m, vint_m, sec_m;
    logic  [2:0] exp_ipl;
    logic  [3:0] rgn;
    logic  [1:0] cs_exp;
    logic  blank, disp, io_like, acc, io_first;
    logic  snd_wr, mcu_wr, mcu_rd, vclr_wr, pri_wr, mix_wr;

    assign rgn      = bus.addr[`MAIN_AW:`MAIN_AW-3];
    assign blank    = ~lvbl | ~lhbl;
    assign disp     = ~bus.as_n & (rgn == `REGION_DISP);
    assign io_like  = (rgn >= `REGION_IO);   // i/o page or unmapped
    assign acc      = ~bus.as_n & ~(bus.uds_n & bus.lds_n);
    assign io_first = acc & ~acc_q & (rgn == `REGION_IO);

    // register accesses seen on the bus, first cycle only
    assign snd_wr  = io_first & ~bus.rnw & (bus.addr[4:1] == `IO_SND);
    assign mcu_wr  = io_first & ~bus.rnw & (bus.addr[4:1] == `IO_MCU);
    assign mcu_rd  = io_first &  bus.rnw & (bus.addr[4:1] == `IO_MCU);
    assign vclr_wr = io_first & ~bus.rnw & (bus.addr[4:1] == `IO_VCLR);
    assign pri_wr  = io_first & ~bus.rnw & (bus.addr[4:1] == `IO_PRISEL);
    assign mix_wr  = io_first & ~bus.rnw & (bus.addr[4:1] == `IO_MIXPSEL);

    // rom select, then ram select shared with display
    assign cs_exp = {acc & (rgn == `REGION_ROM),
                     acc & ((rgn == `REGION_RAM) | (rgn == `REGION_DISP))};

    // register words as the cabinet layout defines them
    always_comb begin
        case (bus.addr[4:1])
            `IO_CAB0: rd_word = {cab.joystick2[7:0], cab.joystick1[7:0]};
            `IO_CAB1: rd_word = {8'hff, ~lvbl, cab.service, cab.coin, cab.start,
                                 cab.joystick2[8], cab.joystick1[8]};
            `IO_DIPS: rd_word = {cab.dipsw_b, cab.dipsw_a};
            `IO_MCU:  rd_word = mcu_dout;
            default:  rd_word = `OPEN_BUS;
        endcase
        if (rgn != `REGION_IO)
            rd_word = `OPEN_BUS;
    end

    always_ff @(posedge clk) begin
        rst_q    <= rst;
        dtack_q  <= dtack_n;
        as_q     <= bus.as_n;
        acc_q    <= acc;
        rom_ok_q <= rom_ok;
        ram_ok_q <= ram_ok;
        blank_q1 <= blank;
        blank_q2 <= blank_q1;
        blank_q3 <= blank_q2;
        dout_q   <= bus.dout;
        rom_q    <= rom_data;
        ram_q    <= ram_data;
        snd_q    <= snd_wr;
        mcuwr_q  <= mcu_wr;
        pri_q    <= pri_wr;
        mix_q    <= mix_wr;
        if (as_q && !bus.as_n)
            rd_exp <= rd_word;     // capture on the first cycle
    end

    // reference interrupt latches
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lvbl_m <= 1'b0;
            sec2_m <= 1'b1;
            vint_m <= 1'b0;
            sec_m  <= 1'b0;
        end else begin
            lvbl_m <= lvbl;
            sec2_m <= sec2;
            if (vclr_wr)
                vint_m <= 1'b0;
            else if (lvbl_m && !lvbl)
                vint_m <= 1'b1;
            if (mcu_rd)
                sec_m <= 1'b0;
            else if (!sec2_m && sec2)
                sec_m <= 1'b1;
        end
    end

    assign exp_ipl = vint_m ? ~`IPL_VBL : sec_m ? ~`IPL_SEC :
                     !nexirq ? ~`IPL_EXT : 3'b111;

    a_reset: assert property (@(posedge clk) rst && rst_q |-> dtack_n && !rom_cs && !ram_cs
        && ipl_n == 3'b111 && !snreq && snd_latch == 8'd0 && mcu_din == '0
        && prisel == 8'd0 && !mixpsel)
        else begin fail_cnt++; $error("outputs not at their inactive level in reset"); end

    a_cs: assert property (@(posedge clk) disable iff (rst) {rom_cs, ram_cs} == cs_exp)
        else begin fail_cnt++; $error("ERR chip_select expected %b actual %b", cs_exp,
            {rom_cs, ram_cs}); end

    a_ipl: assert property (@(posedge clk) disable iff (rst) ipl_n == exp_ipl)
        else begin fail_cnt++; $error("ERR ipl expected %b actual %b", exp_ipl, ipl_n); end

    a_snd: assert property (@(posedge clk) disable iff (rst)
        snd_q |-> snreq && snd_latch == dout_q[7:0])
        else begin fail_cnt++; $error("ERR snd_latch expected %h actual %h", dout_q[7:0],
            snd_latch); end

    a_snreq: assert property (@(posedge clk) disable iff (rst) snreq |-> snd_q)
        else begin fail_cnt++; $error("ERR snreq expected %b actual %b", snd_q, snreq); end

    a_mcu: assert property (@(posedge clk) disable iff (rst) mcuwr_q |-> mcu_din == dout_q)
        else begin fail_cnt++; $error("ERR mcu_din expected %h actual %h", dout_q, mcu_din); end

    a_pri: assert property (@(posedge clk) disable iff (rst)
        pri_q |-> prisel == dout_q[7:0])
        else begin fail_cnt++; $error("ERR prisel expected %h actual %h", dout_q[7:0],
            prisel); end

    a_mix: assert property (@(posedge clk) disable iff (rst) mix_q |-> mixpsel == dout_q[0])
        else begin fail_cnt++; $error("ERR mixpsel expected %b actual %b", dout_q[0],
            mixpsel); end

    a_rd_reg: assert property (@(posedge clk) disable iff (rst)
        dtack_q && !dtack_n && bus.rnw && io_like |-> cpu_din == rd_exp)
        else begin fail_cnt++; $error("ERR reg_read expected %h actual %h", rd_exp, cpu_din); end

    a_io_ack: assert property (@(posedge clk) disable iff (rst)
        as_q && !bus.as_n && io_like |=> !dtack_n)
        else begin fail_cnt++; $error("ERR io_ack expected %b actual %b", 1'b0, dtack_n); end

    a_rom_ack: assert property (@(posedge clk) disable iff (rst)
        rom_cs && rom_ok && dtack_n |=> !dtack_n)
        else begin fail_cnt++; $error("ERR rom_ack expected %b actual %b", 1'b0, dtack_n); end

    a_ram_ack: assert property (@(posedge clk) disable iff (rst)
        ram_cs && rgn == `REGION_RAM && ram_ok && dtack_n |=> !dtack_n)
        else begin fail_cnt++; $error("ERR ram_ack expected %b actual %b", 1'b0, dtack_n); end

    a_rom_wait: assert property (@(posedge clk) disable iff (rst)
        dtack_q && !dtack_n && rgn == `REGION_ROM |-> rom_ok_q && cpu_din == rom_q)
        else begin fail_cnt++; $error("ERR rom_read expected %h actual %h", rom_q, cpu_din); end

    a_ram_wait: assert property (@(posedge clk) disable iff (rst)
        dtack_q && !dtack_n && rgn == `REGION_RAM |-> ram_ok_q
        && (!bus.rnw || cpu_din == ram_q))
        else begin fail_cnt++; $error("ERR ram_read expected %h actual %h", ram_q, cpu_din); end

    a_disp_hold: assert property (@(posedge clk) disable iff (rst)
        disp && dtack_n && !blank && !blank_q1 && !blank_q2 |=> dtack_n)
        else begin fail_cnt++; $error("ERR disp_hold expected %b actual %b", 1'b1, dtack_n); end

    a_disp_ack: assert property (@(posedge clk) disable iff (rst)
        disp && blank && dtack_n && (!blank_q1 || as_q) |=> dtack_n ##1 dtack_n ##1 !dtack_n)
        else begin fail_cnt++; $error("ERR disp_ack expected %b actual %b", 1'b0, dtack_n); end

    a_disp_fall: assert property (@(posedge clk) disable iff (rst)
        dtack_q && !dtack_n && disp |-> blank_q3)
        else begin fail_cnt++; $error("display acknowledge came without a blank"); end

    a_disp_rd: assert property (@(posedge clk) disable iff (rst)
        dtack_q && !dtack_n && disp && bus.rnw |-> cpu_din == ram_q)
        else begin fail_cnt++; $error("ERR disp_read expected %h actual %h", ram_q, cpu_din); end

    a_release: assert property (@(posedge clk) disable iff (rst)
        !dtack_n && bus.as_n |=> dtack_n)
        else begin fail_cnt++; $error("ERR release expected %b actual %b", 1'b1, dtack_n); end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        !dtack_n && !bus.as_n |=> !dtack_n)
        else begin fail_cnt++; $error("ERR dtack_hold expected %b actual %b", 1'b0, dtack_n); end

endmodule

bind main_glue main_glue_sva main_glue_sva_inst (.*);

// ==== verif/main_glue_tb.sv ====
/*
 * testbench of the main bus glue. Acts as the 68000, the memories
 * and the video timing; the bound checker does the comparisons.
 */
`include "main_defs.svh"

module main_glue_tb import main_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int H_CYC      = 16;
    localparam int V_LINES    = 16;
    localparam int FRAME_CYC  = H_CYC * V_LINES;
    localparam int N_ACC      = 80;

    logic       clk, rst, lvbl, lhbl, sec2, nexirq, rom_ok, ram_ok;
    cpu_bus_t   bus;
    word_t      rom_data, ram_data, mcu_dout, cpu_din, mcu_din;
    cab_in_t    cab;
    logic       dtack_n, rom_cs, ram_cs, snreq, mixpsel;
    logic [2:0] ipl_n;
    logic [7:0] snd_latch, prisel;
    logic [3:0] hcnt, vcnt;
    logic [1:0] rom_wait, ram_wait;
    int         seed;
    int         acc_cnt;
    int         errs;

    main_glue main_glue_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // 16 cycle lines, last 4 in hblank; last 3 lines in vblank
    always @(posedge clk, posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
            lhbl <= 1'b1;
            lvbl <= 1'b1;
        end else begin
            hcnt <= hcnt + 4'd1;
            if (hcnt == 4'd15)
                vcnt <= vcnt + 4'd1;
            lhbl <= (hcnt < 4'd11) || (hcnt == 4'd15);
            lvbl <= (vcnt < 4'd13);
        end
    end

    // memories answer after 0 to 3 cycles with address based data
    always @(posedge clk) begin
        if (rom_cs && !rom_ok) begin
            if (rom_wait == 2'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= bus.addr[16:1] ^ 16'hc35a;
            end else
                rom_wait <= rom_wait - 2'd1;
        end else if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= 2'($random(seed));
        end
        if (ram_cs && !ram_ok) begin
            if (ram_wait == 2'd0) begin
                ram_ok   <= 1'b1;
                ram_data <= {bus.addr[8:1], bus.addr[16:9]} ^ 16'h0f0f;
            end else
                ram_wait <= ram_wait - 2'd1;
        end else if (!ram_cs) begin
            ram_ok   <= 1'b0;
            ram_wait <= 2'($random(seed));
        end
    end

    task automatic bus_access(input logic [`MAIN_AW:1] addr, input logic rnw, input word_t data);
        @(posedge clk);
        bus.addr  <= addr;
        bus.rnw   <= rnw;
        bus.dout  <= data;
        bus.as_n  <= 1'b0;
        bus.uds_n <= 1'b0;
        bus.lds_n <= 1'b0;
        @(negedge clk);
        while (dtack_n)
            @(negedge clk);
        @(posedge clk);
        bus.as_n  <= 1'b1;
        bus.uds_n <= 1'b1;
        bus.lds_n <= 1'b1;
        bus.rnw   <= 1'b1;
        repeat (2) @(posedge clk);
        acc_cnt++;
    endtask

    function automatic logic [`MAIN_AW:1] io_addr(input logic [3:0] off);
        return {`REGION_IO, 15'd0, off};
    endfunction

    task automatic shuffle_inputs();
        @(posedge clk);
        cab      <= 39'({$random(seed), $random(seed)});
        mcu_dout <= 16'($random(seed));
    endtask

    initial begin
        seed = 32'h3c0ff2e1;
        acc_cnt = 0;
        clk = 1'b0;
        rst = 1'b1;
        bus = '{addr: '0, as_n: 1'b1, uds_n: 1'b1, lds_n: 1'b1, rnw: 1'b1, dout: '0};
        sec2 = 1'b0;
        nexirq = 1'b1;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        rom_data = '0;
        ram_data = '0;
        rom_wait = '0;
        ram_wait = '0;
        mcu_dout = '0;
        cab = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 4; i++) begin   // cabinet, mcu and open bus reads
            shuffle_inputs();
            bus_access(io_addr(`IO_CAB0), 1'b1, '0);
            bus_access(io_addr(`IO_CAB1), 1'b1, '0);
            bus_access(io_addr(`IO_DIPS), 1'b1, '0);
            bus_access(io_addr(`IO_MCU), 1'b1, '0);
            bus_access({4'd5 + 4'(i), 19'($random(seed))}, 1'b1, '0);
            bus_access(io_addr(`IO_SND), 1'b1, '0);
        end
        for (int i = 0; i < 3; i++) begin   // register writes
            bus_access(io_addr(`IO_SND), 1'b0, 16'($random(seed)));
            bus_access(io_addr(`IO_MCU), 1'b0, 16'($random(seed)));
            bus_access(io_addr(`IO_PRISEL), 1'b0, 16'($random(seed)));
            bus_access(io_addr(`IO_MIXPSEL), 1'b0, 16'($random(seed)));
        end
        for (int i = 0; i < 8; i++) begin   // memory waits
            bus_access({`REGION_ROM, 19'($random(seed))}, 1'b1, '0);
            bus_access({`REGION_RAM, 19'($random(seed))}, 1'b1, '0);
        end
        bus_access({`REGION_RAM, 19'($random(seed))}, 1'b0, 16'($random(seed)));
        for (int i = 0; i < 8; i++) begin   // display waits at varied line positions
            repeat (4'($random(seed))) @(posedge clk);
            bus_access({`REGION_DISP, 19'($random(seed))}, 1'b1, '0);
        end

        // interrupt levels
        @(negedge lvbl);
        repeat (3) @(posedge clk);
        bus_access(io_addr(`IO_VCLR), 1'b0, '0);
        @(posedge clk) sec2 <= 1'b1;
        repeat (3) @(posedge clk);
        sec2 <= 1'b0;
        nexirq <= 1'b0;
        repeat (3) @(posedge clk);
        bus_access(io_addr(`IO_MCU), 1'b1, '0);
        repeat (4) @(posedge clk);
        nexirq <= 1'b1;
        @(negedge lvbl);
        @(posedge clk) sec2 <= 1'b1;
        repeat (4) @(posedge clk);
        sec2 <= 1'b0;
        bus_access(io_addr(`IO_VCLR), 1'b0, '0);
        bus_access(io_addr(`IO_MCU), 1'b1, '0);
        repeat (8) @(posedge clk);

        errs = main_glue_inst.main_glue_sva_inst.fail_cnt;
        $display("accesses %0d, assertion errors %0d", acc_cnt, errs);
        if (errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial begin
        #(20 * N_ACC * FRAME_CYC * CLK_PERIOD);
        $display("watchdog expired, the bus never finished its accesses");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hw/main_pkg.sv
hw/bus_ctrl.sv
hw/irq_ctrl.sv
hw/write_latches.sv
hw/read_mux.sv
hw/main_glue.sv
verif/main_glue_sva.sv
verif/main_glue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the main bus glue testbench with Verilator and runs it

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module main_glue_tb \
    -o main_glue_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/main_glue_sim +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

grep -q "Verification passed" "$LOG"
if [ $? -ne 0 ]; then
    echo "pass message not found in $LOG"
    exit 1
fi

exit 0
